/* Makefile */
TOP := tb_periph_bus

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f all.f

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -Mdir obj_dir -f all.f
	./obj_dir/V$(TOP) > sim.log
	cat sim.log
	! grep -q "RESULT: FAIL" sim.log

clean:
	rm -rf obj_dir sim.log

/* all.f */
verilog/periph_pkg.sv
verilog/periph_addr_decode.sv
verilog/periph_read_return.sv
verilog/gpio_ctrl.sv
verilog/pin_mux.sv
verilog/reg_peri_word.sv
verilog/reg_peri_byte.sv
verilog/periph_bus_top.sv
verif/tb_periph_bus.sv

/* verif/tb_periph_bus.sv */
// Assumes word peripherals in full slots 2 and 3 and byte peripherals in byte slots 0 and 1
module tb_periph_bus;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WORD_SLOT_LO  = 2;
    localparam int NUM_WORD_PERI = 2;
    localparam int NUM_BYTE_PERI = 2;
    localparam int TIMEOUT       = 20;

    logic                                clk;
    logic                                rst_n;
    logic [periph_pkg::PIN_W-1:0]        ui_in;
    logic [periph_pkg::PIN_W-1:0]        uo_out;
    logic [periph_pkg::ADDR_W-1:0]       addr;
    logic [periph_pkg::DATA_W-1:0]       wdata;
    periph_pkg::acc_size_t               write_n;
    periph_pkg::acc_size_t               read_n;
    logic [periph_pkg::DATA_W-1:0]       rdata;
    logic                                data_ready;
    logic                                read_complete;

    // Register model
    logic [periph_pkg::DATA_W-1:0]       word_mem [NUM_WORD_PERI][4];
    logic [periph_pkg::BYTE_W-1:0]       byte_mem [NUM_BYTE_PERI][4];
    logic [periph_pkg::PIN_W-1:0]        gpio_out_m;
    logic [periph_pkg::FUNC_SEL_W-1:0]   sel_m [periph_pkg::PIN_W];
    logic [periph_pkg::PIN_W-1:0]        ui_m;

    logic [31:0] lfsr = 32'h3fa4_38b1;
    int          mismatches = 0;
    int          protocol_errors = 0;
    int          timeouts = 0;

    periph_bus_top #(
        .WORD_SLOT_LO  (WORD_SLOT_LO),
        .NUM_WORD_PERI (NUM_WORD_PERI)
    ) periph_bus_top_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_ui_in         (ui_in),
        .o_uo_out        (uo_out),
        .i_addr          (addr),
        .i_data          (wdata),
        .i_write_n       (write_n),
        .i_read_n        (read_n),
        .o_data          (rdata),
        .o_data_ready    (data_ready),
        .i_read_complete (read_complete)
    );

    always #2 clk = ~clk;

    // Galois LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic periph_pkg::acc_size_t rand_size();
        periph_pkg::acc_size_t s;
        s = periph_pkg::acc_size_t'(2'(rand_bits(2)));
        if (s == periph_pkg::ACC_NONE) begin
            s = periph_pkg::ACC_WORD;
        end
        return s;
    endfunction

    function automatic logic [periph_pkg::ADDR_W-1:0] full_addr(input logic [3:0] slot,
                                                                input logic [5:0] ofs);
        return {1'b0, slot, ofs};
    endfunction

    function automatic logic [periph_pkg::ADDR_W-1:0] byte_addr(input logic [3:0] slot,
                                                                input logic [3:0] ofs);
        return {1'b1, 2'b00, slot, ofs};
    endfunction

    function automatic logic is_word_slot(input int slot);
        return slot >= WORD_SLOT_LO && slot < WORD_SLOT_LO + NUM_WORD_PERI;
    endfunction

    function automatic void predict_write(input logic [periph_pkg::ADDR_W-1:0] a,
                                          input logic [periph_pkg::DATA_W-1:0] d,
                                          input periph_pkg::acc_size_t size);
        int slot;
        int ofs;
        int w;
        int r;
        if (a[10]) begin
            slot = int'(a[7:4]);
            ofs  = int'(a[3:0]);
            if (slot < NUM_BYTE_PERI && ofs < 4) begin
                byte_mem[slot][ofs] = d[7:0];
            end
        end else begin
            slot = int'(a[9:6]);
            ofs  = int'(a[5:0]);
            if (slot == periph_pkg::SLOT_GPIO) begin
                if (ofs == int'(periph_pkg::GPIO_OUT_OFS)) begin
                    gpio_out_m = d[7:0];
                end else if (ofs >= int'(periph_pkg::GPIO_SEL_BASE) && ofs % 4 == 0) begin
                    sel_m[(ofs - int'(periph_pkg::GPIO_SEL_BASE)) / 4] = d[4:0];
                end
            end else if (is_word_slot(slot)) begin
                w = slot - WORD_SLOT_LO;
                r = (ofs / 4) % 4;
                // Narrow sizes touch only the low byte or half
                case (size)
                    periph_pkg::ACC_BYTE: word_mem[w][r][7:0] = d[7:0];
                    periph_pkg::ACC_HALF: word_mem[w][r][15:0] = d[15:0];
                    default: word_mem[w][r] = d;
                endcase
            end
        end
    endfunction

    function automatic logic [periph_pkg::DATA_W-1:0] predict_read(
            input logic [periph_pkg::ADDR_W-1:0] a);
        int slot;
        int ofs;
        if (a[10]) begin
            slot = int'(a[7:4]);
            ofs  = int'(a[3:0]);
            if (slot < NUM_BYTE_PERI && ofs < 4) begin
                return periph_pkg::DATA_W'(byte_mem[slot][ofs]);
            end
            return '0;
        end
        slot = int'(a[9:6]);
        ofs  = int'(a[5:0]);
        if (slot == periph_pkg::SLOT_GPIO) begin
            if (ofs == int'(periph_pkg::GPIO_OUT_OFS)) begin
                return periph_pkg::DATA_W'(gpio_out_m);
            end else if (ofs == int'(periph_pkg::GPIO_IN_OFS)) begin
                return periph_pkg::DATA_W'(ui_m);
            end else if (ofs >= int'(periph_pkg::GPIO_SEL_BASE) && ofs % 4 == 0) begin
                return periph_pkg::DATA_W'(sel_m[(ofs - int'(periph_pkg::GPIO_SEL_BASE)) / 4]);
            end
        end else if (is_word_slot(slot)) begin
            return word_mem[slot - WORD_SLOT_LO][(ofs / 4) % 4];
        end
        return '0;
    endfunction

    function automatic logic [periph_pkg::PIN_W-1:0] expected_pins(
            input logic [periph_pkg::FUNC_SEL_W-1:0] sel);
        int slot;
        slot = int'(sel[3:0]);
        if (sel[4]) begin
            if (slot < NUM_BYTE_PERI) begin
                return byte_mem[slot][0];
            end
        end else if (slot == periph_pkg::SLOT_GPIO) begin
            return gpio_out_m;
        end else if (is_word_slot(slot)) begin
            return word_mem[slot - WORD_SLOT_LO][0][7:0];
        end
        return '0;
    endfunction

    // Word peripherals register their ready and everything else answers at once
    function automatic int read_latency(input logic [periph_pkg::ADDR_W-1:0] a);
        return (!a[10] && is_word_slot(int'(a[9:6]))) ? 2 : 1;
    endfunction

    task automatic check_rdata(input string what, input logic [periph_pkg::DATA_W-1:0] got,
                               input logic [periph_pkg::DATA_W-1:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s gave %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_pins(input string what, input logic [periph_pkg::PIN_W-1:0] got,
                              input logic [periph_pkg::PIN_W-1:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s gave %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic write_reg(input logic [periph_pkg::ADDR_W-1:0] a,
                             input logic [periph_pkg::DATA_W-1:0] d,
                             input periph_pkg::acc_size_t size);
        @(posedge clk);
        addr    <= a;
        wdata   <= d;
        write_n <= size;
        @(negedge clk);
        if (data_ready !== 1'b1) begin
            protocol_errors++;
            $display("The write to address %h was not acknowledged in its own cycle", a);
        end
        predict_write(a, d, size);
        @(posedge clk);
        write_n <= periph_pkg::ACC_NONE;
    endtask

    // Leaves the value held until release_hold frees it
    task automatic read_reg(input logic [periph_pkg::ADDR_W-1:0] a,
                            input periph_pkg::acc_size_t size,
                            output logic [periph_pkg::DATA_W-1:0] data);
        int waited;
        @(posedge clk);
        addr   <= a;
        read_n <= size;
        waited = 0;
        @(negedge clk);
        while (data_ready !== 1'b1 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (data_ready !== 1'b1) begin
            timeouts++;
            $display("Timed out: no o_data_ready for the read of address %h", a);
        end else if (waited != read_latency(a)) begin
            protocol_errors++;
            $display("The read of address %h took %0d cycles instead of %0d",
                     a, waited, read_latency(a));
        end
        data = rdata;
        @(posedge clk);
        read_n <= periph_pkg::ACC_NONE;
    endtask

    task automatic release_hold();
        @(posedge clk);
        read_complete <= 1'b1;
        @(posedge clk);
        read_complete <= 1'b0;
    endtask

    task automatic read_and_check(input logic [periph_pkg::ADDR_W-1:0] a, input string what);
        logic [periph_pkg::DATA_W-1:0] got;
        read_reg(a, rand_size(), got);
        check_rdata(what, got, predict_read(a));
        release_hold();
    endtask

    initial begin
        logic [periph_pkg::ADDR_W-1:0] a;
        logic [periph_pkg::DATA_W-1:0] held;
        logic [periph_pkg::PIN_W-1:0]  exp_pins;
        logic [periph_pkg::PIN_W-1:0]  slot_pins;
        logic [periph_pkg::PIN_W-1:0]  ui_val;
        int                            n;
        clk           = 1'b0;
        rst_n         = 1'b0;
        ui_in         = '0;
        addr          = '0;
        wdata         = '0;
        write_n       = periph_pkg::ACC_NONE;
        read_n        = periph_pkg::ACC_NONE;
        read_complete = 1'b0;
        gpio_out_m    = '0;
        ui_m          = '0;
        for (int i = 0; i < 4; i++) begin
            for (int s = 0; s < NUM_WORD_PERI; s++) begin
                word_mem[s][i] = '0;
            end
            for (int s = 0; s < NUM_BYTE_PERI; s++) begin
                byte_mem[s][i] = '0;
            end
        end
        for (int i = 0; i < periph_pkg::PIN_W; i++) begin
            sel_m[i] = periph_pkg::FUNC_SEL_RESET;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // Reset state
        @(negedge clk);
        check_pins("o_uo_out after reset", uo_out, '0);
        if (data_ready !== 1'b0) begin
            protocol_errors++;
            $display("o_data_ready is high while the bus is idle after reset");
        end
        read_reg(full_addr(4'(periph_pkg::SLOT_GPIO), periph_pkg::GPIO_OUT_OFS),
                 periph_pkg::ACC_WORD, held);
        check_rdata("GPIO output after reset", held, '0);
        release_hold();
        for (int i = 0; i < periph_pkg::PIN_W; i++) begin
            read_reg(full_addr(4'(periph_pkg::SLOT_GPIO), periph_pkg::GPIO_SEL_BASE + 6'(4 * i)),
                     periph_pkg::ACC_WORD, held);
            check_rdata("select after reset", held,
                        periph_pkg::DATA_W'(periph_pkg::FUNC_SEL_RESET));
            release_hold();
        end

        // Sized writes to the word and byte peripherals
        repeat (40) begin
            a = full_addr(4'(WORD_SLOT_LO + rand_bits(1)), 6'(rand_bits(4) << 2));
            write_reg(a, rand_bits(32), rand_size());
            read_and_check(a, "word peripheral read");
            a = byte_addr(4'(rand_bits(1)), 4'(rand_bits(3)));
            write_reg(a, rand_bits(32), rand_size());
            read_and_check(a, "byte peripheral read");
        end

        // GPIO output and input, unused offsets, empty slots
        repeat (4) begin
            a = full_addr(4'(periph_pkg::SLOT_GPIO), periph_pkg::GPIO_OUT_OFS);
            write_reg(a, rand_bits(32), rand_size());
            read_and_check(a, "GPIO output read-back");
            ui_val = periph_pkg::PIN_W'(rand_bits(8));
            @(posedge clk);
            ui_in <= ui_val;
            ui_m = ui_val;
            read_and_check(full_addr(4'(periph_pkg::SLOT_GPIO), periph_pkg::GPIO_IN_OFS),
                           "GPIO input read");
        end
        read_and_check(full_addr(4'(periph_pkg::SLOT_GPIO), 6'h08), "unused GPIO offset");
        read_and_check(full_addr(4'(periph_pkg::SLOT_GPIO), 6'h1c), "unused GPIO offset");
        read_and_check(full_addr(4'h0, 6'h00), "empty full slot 0");
        repeat (6) begin
            a = full_addr(4'(8 + rand_bits(3)), 6'(rand_bits(4) << 2));
            write_reg(a, rand_bits(32), periph_pkg::ACC_WORD);
            read_and_check(a, "empty full slot");
            a = byte_addr(4'(2 + rand_bits(3)), 4'(rand_bits(2)));
            write_reg(a, rand_bits(32), periph_pkg::ACC_WORD);
            read_and_check(a, "empty byte slot");
        end

        // Pin routing with random selects over populated and empty slots
        repeat (12) begin
            for (int s = 0; s < NUM_WORD_PERI; s++) begin
                write_reg(full_addr(4'(WORD_SLOT_LO + s), 6'h00), rand_bits(32),
                          periph_pkg::ACC_WORD);
            end
            for (int s = 0; s < NUM_BYTE_PERI; s++) begin
                write_reg(byte_addr(4'(s), 4'h0), rand_bits(32), periph_pkg::ACC_BYTE);
            end
            write_reg(full_addr(4'(periph_pkg::SLOT_GPIO), periph_pkg::GPIO_OUT_OFS),
                      rand_bits(32), periph_pkg::ACC_WORD);
            for (int i = 0; i < periph_pkg::PIN_W; i++) begin
                write_reg(full_addr(4'(periph_pkg::SLOT_GPIO),
                                    periph_pkg::GPIO_SEL_BASE + 6'(4 * i)),
                          rand_bits(32), periph_pkg::ACC_WORD);
            end
            @(negedge clk);
            for (int i = 0; i < periph_pkg::PIN_W; i++) begin
                slot_pins   = expected_pins(sel_m[i]);
                exp_pins[i] = slot_pins[i];
            end
            check_pins("o_uo_out routing", uo_out, exp_pins);
        end

        // Held read data survives writes and idle cycles until completion
        repeat (8) begin
            case (rand_bits(2))
                0, 1: a = full_addr(4'(WORD_SLOT_LO + rand_bits(1)), 6'(rand_bits(2) << 2));
                2: a = byte_addr(4'(rand_bits(1)), 4'(rand_bits(2)));
                default: a = full_addr(4'(periph_pkg::SLOT_GPIO), periph_pkg::GPIO_OUT_OFS);
            endcase
            write_reg(a, rand_bits(32), periph_pkg::ACC_WORD);
            read_reg(a, periph_pkg::ACC_WORD, held);
            check_rdata("read before hold", held, predict_read(a));
            // The core keeps its read request up while the value is held
            @(posedge clk);
            read_n <= periph_pkg::ACC_WORD;
            n = 1 + int'(rand_bits(3));
            repeat (n) begin
                if (rand_bits(1) == 1) begin
                    write_reg(a, rand_bits(32), rand_size());
                end else begin
                    @(posedge clk);
                end
                @(negedge clk);
                check_rdata("held o_data", rdata, held);
            end
            @(posedge clk);
            read_n <= periph_pkg::ACC_NONE;
            release_hold();
            read_and_check(a, "read after release");
        end

        $display("Errors: %0d mismatches, %0d protocol errors, %0d timeouts",
                 mismatches, protocol_errors, timeouts);
        if (mismatches == 0 && protocol_errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* verilog/gpio_ctrl.sv */
// GPIO registers take writes of any size; select registers keep data bits 4:0 only
module gpio_ctrl (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [periph_pkg::FULL_OFS_W-1:0] i_addr,
    input  logic [periph_pkg::DATA_W-1:0]     i_data,
    input  periph_pkg::acc_size_t             i_write_n,
    input  logic [periph_pkg::PIN_W-1:0]      i_ui_in,
    output logic [periph_pkg::DATA_W-1:0]     o_rdata,
    output logic [periph_pkg::PIN_W-1:0]      o_gpio_out,
    output logic [periph_pkg::FUNC_SEL_W-1:0] o_func_sel [periph_pkg::PIN_W]
);

    localparam int SEL_IDX_W = $clog2(periph_pkg::PIN_W);
    // Offset bits that index the select registers
    localparam logic [periph_pkg::FULL_OFS_W-1:0] SEL_IDX_MASK =
        periph_pkg::FULL_OFS_W'((periph_pkg::PIN_W - 1) << 2);

    logic                 write_en;
    logic                 sel_hit;
    logic [SEL_IDX_W-1:0] sel_idx;

    assign write_en = (i_write_n != periph_pkg::ACC_NONE);
    assign sel_hit  = ((i_addr & ~SEL_IDX_MASK) == periph_pkg::GPIO_SEL_BASE);
    assign sel_idx  = i_addr[2 +: SEL_IDX_W];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_gpio_out <= '0;
        end else if (write_en && i_addr == periph_pkg::GPIO_OUT_OFS) begin
            o_gpio_out <= i_data[periph_pkg::PIN_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < periph_pkg::PIN_W; i++) begin
                o_func_sel[i] <= periph_pkg::FUNC_SEL_RESET;
            end
        end else if (write_en && sel_hit) begin
            o_func_sel[sel_idx] <= i_data[periph_pkg::FUNC_SEL_W-1:0];
        end
    end

    // Read-back is combinational, so the slot is always ready
    always_comb begin
        o_rdata = '0;
        if (i_addr == periph_pkg::GPIO_OUT_OFS) begin
            o_rdata = periph_pkg::DATA_W'(o_gpio_out);
        end else if (i_addr == periph_pkg::GPIO_IN_OFS) begin
            o_rdata = periph_pkg::DATA_W'(i_ui_in);
        end else if (sel_hit) begin
            o_rdata = periph_pkg::DATA_W'(o_func_sel[sel_idx]);
        end
    end

endmodule

/* verilog/periph_addr_decode.sv */
// Full slots other than GPIO and the word peripheral range read as zero and are always ready
module periph_addr_decode #(
    parameter int WORD_SLOT_LO  = 2,
    parameter int NUM_WORD_PERI = 2
) (
    input  logic [periph_pkg::ADDR_W-1:0]    i_addr,
    input  logic [periph_pkg::DATA_W-1:0]    i_user_rdata [periph_pkg::NUM_SLOTS],
    input  logic [periph_pkg::NUM_SLOTS-1:0] i_user_rready,
    input  logic [periph_pkg::BYTE_W-1:0]    i_byte_rdata [periph_pkg::NUM_SLOTS],
    output logic [periph_pkg::NUM_SLOTS-1:0] o_user_sel,
    output logic [periph_pkg::NUM_SLOTS-1:0] o_byte_sel,
    output logic [periph_pkg::DATA_W-1:0]    o_rdata,
    output logic                             o_rready
);

    logic                          byte_class;
    logic [periph_pkg::SLOT_W-1:0] user_slot;
    logic [periph_pkg::SLOT_W-1:0] byte_slot;

    function automatic logic full_populated(input logic [periph_pkg::SLOT_W-1:0] slot);
        int idx;
        idx = int'(slot);
        return (idx == periph_pkg::SLOT_GPIO) ||
               (idx >= WORD_SLOT_LO && idx < WORD_SLOT_LO + NUM_WORD_PERI);
    endfunction

    // Top address bit splits the map into the full and the byte class
    assign byte_class = i_addr[periph_pkg::ADDR_W-1];
    assign user_slot  = i_addr[periph_pkg::FULL_OFS_W +: periph_pkg::SLOT_W];
    assign byte_slot  = i_addr[periph_pkg::BYTE_OFS_W +: periph_pkg::SLOT_W];

    always_comb begin
        o_user_sel = '0;
        o_byte_sel = '0;
        if (byte_class) begin
            o_byte_sel[byte_slot] = 1'b1;
            // Byte peripherals answer in the same cycle
            o_rdata  = periph_pkg::DATA_W'(i_byte_rdata[byte_slot]);
            o_rready = 1'b1;
        end else begin
            o_user_sel[user_slot] = 1'b1;
            if (full_populated(user_slot)) begin
                o_rdata  = i_user_rdata[user_slot];
                o_rready = i_user_rready[user_slot];
            end else begin
                o_rdata  = '0;
                o_rready = 1'b1;
            end
        end
    end

endmodule

/* verilog/periph_bus_top.sv */
// Hub top; a request holds its inputs until o_data_ready, reads need i_read_complete to free the hold
module periph_bus_top #(
    parameter int WORD_SLOT_LO  = 2,
    parameter int NUM_WORD_PERI = 2
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [periph_pkg::PIN_W-1:0]    i_ui_in,
    output logic [periph_pkg::PIN_W-1:0]    o_uo_out,
    input  logic [periph_pkg::ADDR_W-1:0]   i_addr,
    input  logic [periph_pkg::DATA_W-1:0]   i_data,
    input  periph_pkg::acc_size_t           i_write_n,
    input  periph_pkg::acc_size_t           i_read_n,
    output logic [periph_pkg::DATA_W-1:0]   o_data,
    output logic                            o_data_ready,
    input  logic                            i_read_complete
);

    // Byte slots 0 and 1 hold the example byte peripheral
    localparam int NUM_BYTE_PERI = 2;

    logic [periph_pkg::NUM_SLOTS-1:0]  user_sel;
    logic [periph_pkg::NUM_SLOTS-1:0]  byte_sel;
    logic [periph_pkg::DATA_W-1:0]     user_rdata [periph_pkg::NUM_SLOTS];
    logic [periph_pkg::NUM_SLOTS-1:0]  user_rready;
    logic [periph_pkg::BYTE_W-1:0]     byte_rdata [periph_pkg::NUM_SLOTS];
    logic [periph_pkg::PIN_W-1:0]      user_pins [periph_pkg::NUM_SLOTS];
    logic [periph_pkg::PIN_W-1:0]      byte_pins [periph_pkg::NUM_SLOTS];
    logic [periph_pkg::FUNC_SEL_W-1:0] func_sel [periph_pkg::PIN_W];
    logic [periph_pkg::DATA_W-1:0]     sel_rdata;
    logic                              sel_rready;
    logic                              write_active;
    periph_pkg::acc_size_t             read_n_masked;

    assign write_active = (i_write_n != periph_pkg::ACC_NONE);

    periph_addr_decode #(
        .WORD_SLOT_LO  (WORD_SLOT_LO),
        .NUM_WORD_PERI (NUM_WORD_PERI)
    ) periph_addr_decode_i (
        .i_addr        (i_addr),
        .i_user_rdata  (user_rdata),
        .i_user_rready (user_rready),
        .i_byte_rdata  (byte_rdata),
        .o_user_sel    (user_sel),
        .o_byte_sel    (byte_sel),
        .o_rdata       (sel_rdata),
        .o_rready      (sel_rready)
    );

    periph_read_return periph_read_return_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_read_n        (i_read_n),
        .i_write_active  (write_active),
        .i_rdata         (sel_rdata),
        .i_rready        (sel_rready),
        .i_read_complete (i_read_complete),
        .o_read_n_masked (read_n_masked),
        .o_data          (o_data),
        .o_data_ready    (o_data_ready)
    );

    pin_mux pin_mux_i (
        .i_func_sel  (func_sel),
        .i_user_pins (user_pins),
        .i_byte_pins (byte_pins),
        .o_uo_out    (o_uo_out)
    );

    // Full slots, each peripheral sees ACC_NONE unless it is addressed
    for (genvar s = 0; s < periph_pkg::NUM_SLOTS; s++) begin : g_full
        if (s == periph_pkg::SLOT_GPIO) begin : g_gpio
            periph_pkg::acc_size_t slot_write_n;

            assign slot_write_n   = user_sel[s] ? i_write_n : periph_pkg::ACC_NONE;
            assign user_rready[s] = 1'b1;

            gpio_ctrl gpio_ctrl_i (
                .clk        (clk),
                .rst_n      (rst_n),
                .i_addr     (i_addr[periph_pkg::FULL_OFS_W-1:0]),
                .i_data     (i_data),
                .i_write_n  (slot_write_n),
                .i_ui_in    (i_ui_in),
                .o_rdata    (user_rdata[s]),
                .o_gpio_out (user_pins[s]),
                .o_func_sel (func_sel)
            );
        end else if (s >= WORD_SLOT_LO && s < WORD_SLOT_LO + NUM_WORD_PERI) begin : g_word
            periph_pkg::acc_size_t slot_write_n;
            periph_pkg::acc_size_t slot_read_n;

            assign slot_write_n = user_sel[s] ? i_write_n : periph_pkg::ACC_NONE;
            assign slot_read_n  = user_sel[s] ? read_n_masked : periph_pkg::ACC_NONE;

            reg_peri_word reg_peri_word_i (
                .clk       (clk),
                .rst_n     (rst_n),
                .i_addr    (i_addr[periph_pkg::FULL_OFS_W-1:0]),
                .i_data    (i_data),
                .i_write_n (slot_write_n),
                .i_read_n  (slot_read_n),
                .o_rdata   (user_rdata[s]),
                .o_rready  (user_rready[s]),
                .o_pins    (user_pins[s])
            );
        end else begin : g_empty
            assign user_rdata[s]  = '0;
            assign user_rready[s] = 1'b1;
            assign user_pins[s]   = '0;
        end
    end

    // Byte slots take a plain write strobe and the low data byte
    for (genvar s = 0; s < periph_pkg::NUM_SLOTS; s++) begin : g_byte
        if (s < NUM_BYTE_PERI) begin : g_reg
            logic slot_write;

            assign slot_write = byte_sel[s] && write_active;

            reg_peri_byte reg_peri_byte_i (
                .clk     (clk),
                .rst_n   (rst_n),
                .i_addr  (i_addr[periph_pkg::BYTE_OFS_W-1:0]),
                .i_write (slot_write),
                .i_data  (i_data[periph_pkg::BYTE_W-1:0]),
                .o_rdata (byte_rdata[s]),
                .o_pins  (byte_pins[s])
            );
        end else begin : g_empty
            assign byte_rdata[s] = '0;
            assign byte_pins[s]  = '0;
        end
    end

endmodule

/* verilog/periph_pkg.sv */
// Shared widths, access codes and GPIO map; the byte class and the full class each have 16 slots
package periph_pkg;

    // Bus and pin widths
    localparam int ADDR_W     = 11;
    localparam int DATA_W     = 32;
    localparam int BYTE_W     = 8;
    localparam int PIN_W      = 8;

    // Slot addressing
    localparam int SLOT_W     = 4;
    localparam int NUM_SLOTS  = 16;
    // Offset bits inside a 64 byte full slot and a 16 byte byte slot
    localparam int FULL_OFS_W = 6;
    localparam int BYTE_OFS_W = 4;

    // Pin function select, top bit picks the byte class
    localparam int FUNC_SEL_W = 5;

    // Transfer size code, shared by write and read requests
    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10,
        ACC_NONE = 2'b11
    } acc_size_t;

    // Fixed slot of the GPIO block in the full class
    localparam int SLOT_GPIO = 1;

    // GPIO register offsets within its slot
    localparam logic [FULL_OFS_W-1:0] GPIO_OUT_OFS  = 6'h00;
    localparam logic [FULL_OFS_W-1:0] GPIO_IN_OFS   = 6'h04;
    // Eight select registers follow on word steps
    localparam logic [FULL_OFS_W-1:0] GPIO_SEL_BASE = 6'h20;

    // After reset every pin shows the GPIO output register
    localparam logic [FUNC_SEL_W-1:0] FUNC_SEL_RESET = FUNC_SEL_W'(SLOT_GPIO);

endpackage

/* verilog/periph_read_return.sv */
// Read data is held until i_read_complete; a read seen while a value is held waits for the release
module periph_read_return (
    input  logic                          clk,
    input  logic                          rst_n,
    input  periph_pkg::acc_size_t         i_read_n,
    input  logic                          i_write_active,
    input  logic [periph_pkg::DATA_W-1:0] i_rdata,
    input  logic                          i_rready,
    input  logic                          i_read_complete,
    output periph_pkg::acc_size_t         o_read_n_masked,
    output logic [periph_pkg::DATA_W-1:0] o_data,
    output logic                          o_data_ready
);

    logic                          hold;
    logic                          ready_r;
    logic                          capture;
    logic [periph_pkg::DATA_W-1:0] data_r;

    assign capture = !hold && i_rready && (i_read_n != periph_pkg::ACC_NONE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold <= 1'b0;
            end
            if (capture) begin
                hold <= 1'b1;
            end
            ready_r <= capture;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_r <= i_rdata;
        end
    end

    // Peripherals must not see the same read again while the core takes the data
    assign o_read_n_masked = ready_r ? periph_pkg::ACC_NONE : i_read_n;
    assign o_data          = data_r;
    assign o_data_ready    = ready_r || i_write_active;

endmodule

/* verilog/pin_mux.sv */
// Pure combinational routing; unpopulated slots must present zero pins to keep their outputs low
module pin_mux (
    input  logic [periph_pkg::FUNC_SEL_W-1:0] i_func_sel [periph_pkg::PIN_W],
    input  logic [periph_pkg::PIN_W-1:0]      i_user_pins [periph_pkg::NUM_SLOTS],
    input  logic [periph_pkg::PIN_W-1:0]      i_byte_pins [periph_pkg::NUM_SLOTS],
    output logic [periph_pkg::PIN_W-1:0]      o_uo_out
);

    logic [periph_pkg::SLOT_W-1:0] slot;
    logic                          byte_class;

    always_comb begin
        slot       = '0;
        byte_class = 1'b0;
        for (int i = 0; i < periph_pkg::PIN_W; i++) begin
            slot       = i_func_sel[i][periph_pkg::SLOT_W-1:0];
            byte_class = i_func_sel[i][periph_pkg::FUNC_SEL_W-1];
            // Pin i always takes bit i of the chosen slot
            if (byte_class) begin
                o_uo_out[i] = i_byte_pins[slot][i];
            end else begin
                o_uo_out[i] = i_user_pins[slot][i];
            end
        end
    end

endmodule

/* verilog/reg_peri_byte.sv */
// Four byte registers at offsets 0 to 3; writes elsewhere are dropped and reads there give 0
module reg_peri_byte (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [periph_pkg::BYTE_OFS_W-1:0] i_addr,
    input  logic                              i_write,
    input  logic [periph_pkg::BYTE_W-1:0]     i_data,
    output logic [periph_pkg::BYTE_W-1:0]     o_rdata,
    output logic [periph_pkg::PIN_W-1:0]      o_pins
);

    logic [periph_pkg::BYTE_W-1:0] regs [4];
    logic                          in_range;

    assign in_range = (i_addr < 4);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (i_write && in_range) begin
            regs[i_addr[1:0]] <= i_data;
        end
    end

    assign o_rdata = in_range ? regs[i_addr[1:0]] : '0;
    assign o_pins  = periph_pkg::PIN_W'(regs[0]);

endmodule

/* verilog/reg_peri_word.sv */
// Offset bits 5:4 are not decoded, so the four registers repeat across the 64 byte slot
module reg_peri_word (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [periph_pkg::FULL_OFS_W-1:0] i_addr,
    input  logic [periph_pkg::DATA_W-1:0]     i_data,
    input  periph_pkg::acc_size_t             i_write_n,
    input  periph_pkg::acc_size_t             i_read_n,
    output logic [periph_pkg::DATA_W-1:0]     o_rdata,
    output logic                              o_rready,
    output logic [periph_pkg::PIN_W-1:0]      o_pins
);

    logic [periph_pkg::DATA_W-1:0] regs [4];
    logic [1:0]                    idx;

    assign idx = i_addr[3:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // Narrow writes leave the upper bits untouched
            case (i_write_n)
                periph_pkg::ACC_BYTE: regs[idx][7:0]  <= i_data[7:0];
                periph_pkg::ACC_HALF: regs[idx][15:0] <= i_data[15:0];
                periph_pkg::ACC_WORD: regs[idx]       <= i_data;
                default: ;
            endcase
        end
    end

    // Ready one cycle after the read, the address is still held by the core
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_rready <= 1'b0;
        end else begin
            o_rready <= (i_read_n != periph_pkg::ACC_NONE);
        end
    end

    assign o_rdata = regs[idx];
    assign o_pins  = regs[0][periph_pkg::PIN_W-1:0];

endmodule
